// ==== bench/tb_rename_unit.sv ====
`timescale 1ns/1ps

module tb_rename_unit;
    import rename_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int ACK_WAIT   = 20;
    // reset, six tests, then margin
    localparam int RUN_CYCLES = 5 + 40 + 60 + 40 + 80 + 120 + 40 + 100;

    logic                   clk_i = 1'b0;
    logic                   rst_n_i;
    logic                   req_i;
    logic                   ack_o;
    logic                   dst_en_i;
    reg_idx_t               rs1_i;
    reg_idx_t               rs2_i;
    reg_idx_t               rd_i;
    data_t                  src1_data_o;
    data_t                  src2_data_o;
    logic                   src1_rdy_o;
    logic                   src2_rdy_o;
    rrf_tag_t               dst_tag_o;
    logic                   dst_valid_o;
    free_cnt_t              free_cnt_o;
    logic [NUM_FWD-1:0]     fwd_we_i;
    rrf_tag_t [NUM_FWD-1:0] fwd_tag_i;
    data_t [NUM_FWD-1:0]    fwd_data_i;
    logic                   com_valid_i;
    logic                   com_we_i;
    reg_idx_t               com_dst_i;
    rrf_tag_t               com_tag_i;

    // reference model state
    data_t    m_arf [NUM_ARCH_REGS];
    logic     m_busy [NUM_ARCH_REGS];
    rrf_tag_t m_tag [NUM_ARCH_REGS];
    data_t    m_rrf [NUM_RRF];
    logic     m_valid [NUM_RRF];
    rrf_tag_t m_ptr;
    int       m_free;
    logic     m_hold;
    data_t    exp_data [NUM_SRC];
    logic     exp_rdy [NUM_SRC];
    rrf_tag_t exp_tag;
    logic     exp_dv;

    logic [31:0] lfsr = 32'd68661;
    int          errs = 0;
    int          errs_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    reg_idx_t    tag_dst [NUM_RRF];
    rrf_tag_t    com_head = '0;
    rrf_tag_t    got_tag;
    data_t       got_data1;
    logic        got_rdy1;

    rename_unit UUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .ack_o       (ack_o),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .rd_i        (rd_i),
        .dst_en_i    (dst_en_i),
        .src1_data_o (src1_data_o),
        .src1_rdy_o  (src1_rdy_o),
        .src2_data_o (src2_data_o),
        .src2_rdy_o  (src2_rdy_o),
        .dst_tag_o   (dst_tag_o),
        .dst_valid_o (dst_valid_o),
        .free_cnt_o  (free_cnt_o),
        .fwd_we_i    (fwd_we_i),
        .fwd_tag_i   (fwd_tag_i),
        .fwd_data_i  (fwd_data_i),
        .com_valid_i (com_valid_i),
        .com_dst_i   (com_dst_i),
        .com_we_i    (com_we_i),
        .com_tag_i   (com_tag_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            // galois step with taps 32 22 2 1
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic reg_idx_t rand_reg();
        reg_idx_t r;
        r = reg_idx_t'(rand_bits(REG_SEL));
        return (r == '0) ? reg_idx_t'(1) : r;
    endfunction

    task automatic log_error(input string msg);
        errs++;
        $display("ERR %0t ns: %s", $time, msg);
    endtask

    // operand value as seen at a capture edge
    task automatic resolve(input reg_idx_t r, output data_t d, output logic rdy);
        rrf_tag_t t;
        t = m_tag[r];
        d = data_t'(t);
        rdy = 1'b0;
        if (r == '0) begin
            d = '0;
            rdy = 1'b1;
        end else if (!m_busy[r]) begin
            d = m_arf[r];
            rdy = 1'b1;
        end else begin
            if (m_valid[t]) begin
                d = m_rrf[t];
                rdy = 1'b1;
            end
            for (int f = 0; f < NUM_FWD; f++) begin
                if (fwd_we_i[f] && fwd_tag_i[f] == t) begin
                    d = fwd_data_i[f];
                    rdy = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk_i) begin : model_step
        logic cap;
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                m_arf[r]  = '0;
                m_busy[r] = 1'b0;
                m_tag[r]  = '0;
            end
            for (int e = 0; e < NUM_RRF; e++) begin
                m_rrf[e]   = '0;
                m_valid[e] = 1'b0;
            end
            m_ptr  = '0;
            m_free = NUM_RRF;
            m_hold = 1'b0;
        end else begin
            cap = !m_hold && req_i && (!dst_en_i || m_free != 0);
            if (cap) begin
                resolve(rs1_i, exp_data[0], exp_rdy[0]);
                resolve(rs2_i, exp_data[1], exp_rdy[1]);
                exp_tag = m_ptr;
                exp_dv  = dst_en_i;
            end
            if (com_valid_i && com_we_i && com_dst_i != '0) begin
                m_arf[com_dst_i] = m_rrf[com_tag_i];
                if (m_tag[com_dst_i] == com_tag_i) begin
                    m_busy[com_dst_i] = 1'b0;
                end
            end
            for (int f = 0; f < NUM_FWD; f++) begin
                if (fwd_we_i[f]) begin
                    m_rrf[fwd_tag_i[f]]   = fwd_data_i[f];
                    m_valid[fwd_tag_i[f]] = 1'b1;
                end
            end
            if (cap && dst_en_i) begin
                if (rd_i != '0) begin
                    m_busy[rd_i] = 1'b1;
                    m_tag[rd_i]  = m_ptr;
                end
                m_valid[m_ptr] = 1'b0;
                m_ptr = m_ptr + 1'b1;
            end
            m_free = m_free - int'(cap && dst_en_i) + int'(com_valid_i);
            if (cap) begin
                m_hold = 1'b1;
            end else if (!req_i) begin
                m_hold = 1'b0;
            end
        end
    end

    // registered outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            assert (ack_o === m_hold)
                else log_error($sformatf("ack_o is %b, expected %b", ack_o, m_hold));
            assert (free_cnt_o === free_cnt_t'(m_free))
                else log_error($sformatf("free_cnt_o is %0d, expected %0d", free_cnt_o, m_free));
            if (m_hold) begin
                assert (dst_valid_o === exp_dv) else log_error("dst_valid_o wrong during ack");
                assert (src1_data_o === exp_data[0] && src1_rdy_o === exp_rdy[0])
                    else log_error($sformatf("src1 %h/%b, expected %h/%b", src1_data_o,
                                             src1_rdy_o, exp_data[0], exp_rdy[0]));
                assert (src2_data_o === exp_data[1] && src2_rdy_o === exp_rdy[1])
                    else log_error($sformatf("src2 %h/%b, expected %h/%b", src2_data_o,
                                             src2_rdy_o, exp_data[1], exp_rdy[1]));
                if (exp_dv) begin
                    assert (dst_tag_o === exp_tag)
                        else log_error($sformatf("dst_tag_o %0d, expected %0d",
                                                 dst_tag_o, exp_tag));
                end
            end else begin
                assert (dst_valid_o === 1'b0) else log_error("dst_valid_o high without ack");
            end
        end
    end

    // four-phase rule
    assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_o && req_i |=> ack_o)
        else log_error("ack dropped while req still high");
    assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_o && !req_i |=> !ack_o)
        else log_error("ack still high one cycle after req fell");

    task automatic raise_req(input reg_idx_t r1, input reg_idx_t r2, input reg_idx_t rd,
                             input logic den);
        rs1_i    = r1;
        rs2_i    = r2;
        rd_i     = rd;
        dst_en_i = den;
        req_i    = 1'b1;
    endtask

    task automatic finish_handshake();
        int n;
        n = 0;
        while (!ack_o && n < ACK_WAIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!ack_o) begin
            errs++;
            $display("no ack within %0d cycles of the request, at %0t ns", ACK_WAIT, $time);
        end
        // one more cycle with req still high so ack has to hold
        @(negedge clk_i);
        got_tag   = dst_tag_o;
        got_data1 = src1_data_o;
        got_rdy1  = src1_rdy_o;
        if (dst_en_i) begin
            tag_dst[exp_tag] = rd_i;
        end
        req_i = 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (ack_o && n < ACK_WAIT);
        assert (n == 1 && !ack_o) else log_error("ack did not drop one cycle after req fell");
    endtask

    task automatic dispatch(input reg_idx_t r1, input reg_idx_t r2, input reg_idx_t rd,
                            input logic den);
        raise_req(r1, r2, rd, den);
        finish_handshake();
    endtask

    task automatic fwd_set(input int p, input rrf_tag_t t, input data_t d);
        fwd_we_i[p]   = 1'b1;
        fwd_tag_i[p]  = t;
        fwd_data_i[p] = d;
    endtask

    // oldest entry gets its result, then retires
    task automatic retire_next();
        fwd_set(0, com_head, rand_bits(DATA_W));
        @(negedge clk_i);
        fwd_we_i    = '0;
        com_valid_i = 1'b1;
        com_we_i    = 1'b1;
        com_dst_i   = tag_dst[com_head];
        com_tag_i   = com_head;
        @(negedge clk_i);
        com_valid_i = 1'b0;
        com_we_i    = 1'b0;
        com_head    = com_head + 1'b1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errs == errs_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs - errs_mark);
        end
        errs_mark = errs;
    endtask

    initial begin : main
        rrf_tag_t prev_tag;
        int       cnt_before;
        reg_idx_t rd;
        data_t    byp;
        rst_n_i     = 1'b0;
        req_i       = 1'b0;
        dst_en_i    = 1'b0;
        rs1_i       = '0;
        rs2_i       = '0;
        rd_i        = '0;
        fwd_we_i    = '0;
        fwd_tag_i   = '0;
        fwd_data_i  = '0;
        com_valid_i = 1'b0;
        com_we_i    = 1'b0;
        com_dst_i   = '0;
        com_tag_i   = '0;
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        assert (!ack_o && !dst_valid_o && free_cnt_o == free_cnt_t'(NUM_RRF))
            else log_error("outputs not in reset state");
        repeat (4) begin
            dispatch(reg_idx_t'(rand_bits(REG_SEL)), reg_idx_t'(rand_bits(REG_SEL)),
                     rand_reg(), 1'b0);
            assert (got_data1 == '0 && got_rdy1) else log_error("fresh register not zero");
        end
        end_test("reset state");

        prev_tag = rrf_tag_t'(NUM_RRF - 1);
        repeat (6) begin
            cnt_before = m_free;
            dispatch(rand_reg(), rand_reg(), rand_reg(), 1'b1);
            assert (got_tag == rrf_tag_t'(prev_tag + 1'b1)) else log_error("tag not in sequence");
            assert (int'(free_cnt_o) == cnt_before - 1) else log_error("count did not drop");
            prev_tag = exp_tag;
        end
        dispatch(tag_dst[5], '0, '0, 1'b0);
        assert (!got_rdy1 && got_data1 == data_t'(5)) else log_error("renamed reg lost its tag");
        end_test("rename sequence");

        fwd_set(0, rrf_tag_t'(0), rand_bits(DATA_W));
        fwd_set(1, rrf_tag_t'(1), rand_bits(DATA_W));
        fwd_set(2, rrf_tag_t'(2), rand_bits(DATA_W));
        @(negedge clk_i);
        fwd_we_i = '0;
        dispatch(tag_dst[0], tag_dst[1], '0, 1'b0);
        dispatch(tag_dst[2], '0, '0, 1'b0);
        // tag 5 result lands on the capture edge itself
        byp = rand_bits(DATA_W);
        fwd_set(2, rrf_tag_t'(5), byp);
        fork
            dispatch(tag_dst[5], tag_dst[4], '0, 1'b0);
            begin
                @(negedge clk_i);
                fwd_we_i = '0;
            end
        join
        assert (got_rdy1 && got_data1 == byp) else log_error("bypass result not seen");
        end_test("forwarding");

        repeat (3) begin
            cnt_before = m_free;
            retire_next();
            assert (int'(free_cnt_o) == cnt_before + 1) else log_error("commit freed no entry");
        end
        dispatch(tag_dst[0], tag_dst[1], '0, 1'b0);
        rd = tag_dst[3];
        dispatch('0, '0, rd, 1'b1);
        retire_next();
        dispatch(rd, '0, '0, 1'b0);
        assert (!got_rdy1 && got_data1 == data_t'(6)) else log_error("newer rename cleared");
        repeat (2) retire_next();
        end_test("commit");

        repeat (NUM_RRF - 1) dispatch(rand_reg(), rand_reg(), rand_reg(), 1'b1);
        assert (free_cnt_o == '0) else log_error("rrf not full");
        raise_req(rand_reg(), rand_reg(), rand_reg(), 1'b1);
        repeat (8) begin
            @(negedge clk_i);
            assert (!ack_o) else log_error("ack with no free entry");
        end
        retire_next();
        finish_handshake();
        // pointer wrapped onto the entry just freed
        assert (got_tag == rrf_tag_t'(6) && free_cnt_o == '0) else log_error("stall not released");
        end_test("back-pressure");

        repeat (2) retire_next();
        repeat (2) begin
            dispatch('0, '0, '0, 1'b1);
            dispatch('0, '0, '0, 1'b0);
            assert (got_data1 == '0 && got_rdy1) else log_error("register 0 not zero and ready");
        end
        end_test("register 0");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errs);
        if (errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog: run still going after %0d cycles", RUN_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== design/arch_reg_file.sv ====
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    operand_lookup_if.arf         lookup [rename_pkg::NUM_SRC],
    commit_if.arf                 cm,
    input  logic                  alloc_i,
    input  rename_pkg::reg_idx_t  rd_i,
    input  rename_pkg::rrf_tag_t  alloc_tag_i
);
    import rename_pkg::*;

    data_t                    arf_data [NUM_ARCH_REGS];
    rrf_tag_t                 arf_tag  [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] arf_busy;

    logic com_write;
    logic com_tag_match;
    logic set_busy;

    assign com_write     = cm.valid && cm.we && (cm.dst_idx != '0);
    assign com_tag_match = (arf_tag[cm.dst_idx] == cm.tag);

    // r0 is never renamed
    assign set_busy = alloc_i && (rd_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arf_busy <= '0;
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                arf_data[r] <= '0;
                arf_tag[r]  <= '0;
            end
        end else begin
            if (com_write) begin
                arf_data[cm.dst_idx] <= cm.data;
                // a newer rename keeps the register busy
                if (com_tag_match) begin
                    arf_busy[cm.dst_idx] <= 1'b0;
                end
            end
            // set-busy overrides a clear on the same edge
            if (set_busy) begin
                arf_busy[rd_i] <= 1'b1;
                arf_tag[rd_i]  <= alloc_tag_i;
            end
        end
    end

    // combinational read ports, state before this edge's updates
    for (genvar s = 0; s < NUM_SRC; s++) begin : g_rd
        assign lookup[s].arf_busy = arf_busy[lookup[s].src_idx];
        assign lookup[s].arf_data = arf_data[lookup[s].src_idx];
        assign lookup[s].arf_tag  = arf_tag[lookup[s].src_idx];
    end

endmodule

// ==== design/commit_if.sv ====
`timescale 1ns/1ps

interface commit_if;
    import rename_pkg::*;

    logic     valid;
    reg_idx_t dst_idx;
    logic     we;
    rrf_tag_t tag;

    // data of the retiring rrf entry
    data_t data;

    modport rrf (input tag, output data);

    modport arf (input valid, dst_idx, we, tag, data);

endinterface

// ==== design/dispatch_ctrl.sv ====
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        req_i,
    input  logic                                        dst_en_i,
    input  rename_pkg::free_cnt_t                       free_cnt_i,
    input  rename_pkg::rrf_tag_t                        alloc_tag_i,
    input  rename_pkg::data_t [rename_pkg::NUM_SRC-1:0] res_data_i,
    input  logic [rename_pkg::NUM_SRC-1:0]              res_rdy_i,
    output logic                                        alloc_o,
    output logic                                        ack_o,
    output rename_pkg::data_t [rename_pkg::NUM_SRC-1:0] src_data_o,
    output logic [rename_pkg::NUM_SRC-1:0]              src_rdy_o,
    output rename_pkg::rrf_tag_t                        dst_tag_o,
    output logic                                        dst_valid_o
);
    import rename_pkg::*;

    disp_state_e state;
    logic        capture;

    // no free entry stalls only requests that need a destination
    assign capture = (state == IDLE) && req_i && (!dst_en_i || (free_cnt_i != '0));
    assign alloc_o = capture && dst_en_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            dst_valid_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (capture) begin
                        state       <= HOLD;
                        dst_valid_o <= dst_en_i;
                    end
                end
                HOLD: begin
                    // upstream dropped req, finish the four phases
                    if (!req_i) begin
                        state       <= IDLE;
                        dst_valid_o <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ack_o = (state == HOLD);

    // operands and tag held for the whole ack phase
    always_ff @(posedge clk_i) begin
        if (capture) begin
            src_data_o <= res_data_i;
            src_rdy_o  <= res_rdy_i;
            dst_tag_o  <= alloc_tag_i;
        end
    end

endmodule

// ==== design/operand_lookup_if.sv ====
`timescale 1ns/1ps

interface operand_lookup_if;
    import rename_pkg::*;

    reg_idx_t src_idx;

    // arf side
    logic     arf_busy;
    data_t    arf_data;
    rrf_tag_t arf_tag;

    // rrf entry picked by arf_tag
    logic  rrf_valid;
    data_t rrf_data;

    modport arf (input src_idx, output arf_busy, arf_data, arf_tag);

    modport rrf (input arf_tag, output rrf_valid, rrf_data);

    modport resolver (
        input src_idx, arf_busy, arf_data, arf_tag, rrf_valid, rrf_data
    );

endinterface

// ==== design/operand_resolver.sv ====
`timescale 1ns/1ps

module operand_resolver (
    operand_lookup_if.resolver lookup,
    output rename_pkg::data_t  src_data_o,
    output logic               src_rdy_o
);
    import rename_pkg::*;

    always_comb begin
        if (lookup.src_idx == '0) begin
            // r0 hardwired to zero
            src_data_o = '0;
            src_rdy_o  = 1'b1;
        end else if (!lookup.arf_busy) begin
            src_data_o = lookup.arf_data;
            src_rdy_o  = 1'b1;
        end else if (lookup.rrf_valid) begin
            src_data_o = lookup.rrf_data;
            src_rdy_o  = 1'b1;
        end else begin
            // pending, pass the tag to wait on
            src_data_o = data_t'(lookup.arf_tag);
            src_rdy_o  = 1'b0;
        end
    end

endmodule

// ==== design/rename_buffer.sv ====
`timescale 1ns/1ps

module rename_buffer (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    operand_lookup_if.rrf                               lookup [rename_pkg::NUM_SRC],
    commit_if.rrf                                       cm,
    input  logic [rename_pkg::NUM_FWD-1:0]              fwd_we_i,
    input  rename_pkg::rrf_tag_t [rename_pkg::NUM_FWD-1:0] fwd_tag_i,
    input  rename_pkg::data_t [rename_pkg::NUM_FWD-1:0] fwd_data_i,
    input  logic                                        alloc_i,
    input  rename_pkg::rrf_tag_t                        alloc_tag_i
);
    import rename_pkg::*;

    data_t              rrf_data [NUM_RRF];
    logic [NUM_RRF-1:0] rrf_valid;

    always_ff @(posedge clk_i) begin
        for (int f = 0; f < NUM_FWD; f++) begin
            if (fwd_we_i[f]) begin
                rrf_data[fwd_tag_i[f]] <= fwd_data_i[f];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rrf_valid <= '0;
        end else begin
            for (int f = 0; f < NUM_FWD; f++) begin
                if (fwd_we_i[f]) begin
                    rrf_valid[fwd_tag_i[f]] <= 1'b1;
                end
            end
            // fresh entry waits for its result
            if (alloc_i) begin
                rrf_valid[alloc_tag_i] <= 1'b0;
            end
        end
    end

    for (genvar s = 0; s < NUM_SRC; s++) begin : g_rd
        logic  byp_hit;
        data_t byp_data;

        // forwarding in the same cycle bypasses the array
        always_comb begin
            byp_hit  = 1'b0;
            byp_data = rrf_data[lookup[s].arf_tag];
            for (int f = 0; f < NUM_FWD; f++) begin
                if (fwd_we_i[f] && (fwd_tag_i[f] == lookup[s].arf_tag)) begin
                    byp_hit  = 1'b1;
                    byp_data = fwd_data_i[f];
                end
            end
        end

        assign lookup[s].rrf_valid = rrf_valid[lookup[s].arf_tag] | byp_hit;
        assign lookup[s].rrf_data  = byp_data;
    end

    // retiring entry, handed to the arf
    assign cm.data = rrf_data[cm.tag];

endmodule

// ==== design/rename_pkg.sv ====
package rename_pkg;

    // architectural register file
    localparam int NUM_ARCH_REGS = 32;
    localparam int REG_SEL       = 5;

    // rename register file
    localparam int NUM_RRF = 16;
    localparam int RRF_SEL = 4;

    localparam int DATA_W = 32;

    // forwarding ports: 0 alu, 1 mul, 2 ldst
    localparam int NUM_FWD = 3;

    localparam int NUM_SRC = 2;

    typedef logic [REG_SEL-1:0] reg_idx_t;
    typedef logic [RRF_SEL-1:0] rrf_tag_t;
    typedef logic [DATA_W-1:0]  data_t;

    // one extra bit so a completely free RRF can be counted
    typedef logic [RRF_SEL:0] free_cnt_t;

    // dispatch handshake
    typedef enum logic {
        IDLE,
        HOLD
    } disp_state_e;

endpackage

// ==== design/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,

    // dispatch handshake
    input  logic                                           req_i,
    output logic                                           ack_o,
    input  rename_pkg::reg_idx_t                           rs1_i,
    input  rename_pkg::reg_idx_t                           rs2_i,
    input  rename_pkg::reg_idx_t                           rd_i,
    input  logic                                           dst_en_i,

    output rename_pkg::data_t                              src1_data_o,
    output logic                                           src1_rdy_o,
    output rename_pkg::data_t                              src2_data_o,
    output logic                                           src2_rdy_o,
    output rename_pkg::rrf_tag_t                           dst_tag_o,
    output logic                                           dst_valid_o,
    output rename_pkg::free_cnt_t                          free_cnt_o,

    // result forwarding, index 0 alu, 1 mul, 2 ldst
    input  logic [rename_pkg::NUM_FWD-1:0]                 fwd_we_i,
    input  rename_pkg::rrf_tag_t [rename_pkg::NUM_FWD-1:0] fwd_tag_i,
    input  rename_pkg::data_t [rename_pkg::NUM_FWD-1:0]    fwd_data_i,

    // retirement
    input  logic                                           com_valid_i,
    input  rename_pkg::reg_idx_t                           com_dst_i,
    input  logic                                           com_we_i,
    input  rename_pkg::rrf_tag_t                           com_tag_i
);
    import rename_pkg::*;

    operand_lookup_if lookup [NUM_SRC] ();
    commit_if         cm ();

    reg_idx_t [NUM_SRC-1:0] src_idx;
    data_t [NUM_SRC-1:0]    res_data;
    logic [NUM_SRC-1:0]     res_rdy;
    data_t [NUM_SRC-1:0]    src_data;
    logic [NUM_SRC-1:0]     src_rdy;

    logic      alloc;
    rrf_tag_t  alloc_tag;
    free_cnt_t free_cnt;

    assign src_idx = {rs2_i, rs1_i};

    assign cm.valid   = com_valid_i;
    assign cm.dst_idx = com_dst_i;
    assign cm.we      = com_we_i;
    assign cm.tag     = com_tag_i;

    arch_reg_file u_arf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lookup      (lookup),
        .cm          (cm),
        .alloc_i     (alloc),
        .rd_i        (rd_i),
        .alloc_tag_i (alloc_tag)
    );

    rename_buffer u_rrf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lookup      (lookup),
        .cm          (cm),
        .fwd_we_i    (fwd_we_i),
        .fwd_tag_i   (fwd_tag_i),
        .fwd_data_i  (fwd_data_i),
        .alloc_i     (alloc),
        .alloc_tag_i (alloc_tag)
    );

    rrf_allocator u_alloc (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alloc_i     (alloc),
        .commit_i    (com_valid_i),
        .alloc_tag_o (alloc_tag),
        .free_cnt_o  (free_cnt)
    );

    for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
        assign lookup[s].src_idx = src_idx[s];

        operand_resolver u_resolver (
            .lookup     (lookup[s]),
            .src_data_o (res_data[s]),
            .src_rdy_o  (res_rdy[s])
        );
    end

    dispatch_ctrl u_disp (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .dst_en_i    (dst_en_i),
        .free_cnt_i  (free_cnt),
        .alloc_tag_i (alloc_tag),
        .res_data_i  (res_data),
        .res_rdy_i   (res_rdy),
        .alloc_o     (alloc),
        .ack_o       (ack_o),
        .src_data_o  (src_data),
        .src_rdy_o   (src_rdy),
        .dst_tag_o   (dst_tag_o),
        .dst_valid_o (dst_valid_o)
    );

    assign src1_data_o = src_data[0];
    assign src1_rdy_o  = src_rdy[0];
    assign src2_data_o = src_data[1];
    assign src2_rdy_o  = src_rdy[1];
    assign free_cnt_o  = free_cnt;

endmodule

// ==== design/rrf_allocator.sv ====
`timescale 1ns/1ps

module rrf_allocator (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  alloc_i,
    input  logic                  commit_i,
    output rename_pkg::rrf_tag_t  alloc_tag_o,
    output rename_pkg::free_cnt_t free_cnt_o
);
    import rename_pkg::*;

    rrf_tag_t  alloc_ptr;
    free_cnt_t free_cnt;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alloc_ptr <= '0;
        end else if (alloc_i) begin
            if (alloc_ptr == rrf_tag_t'(NUM_RRF - 1)) begin
                alloc_ptr <= '0;
            end else begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
        end
    end

    // commits free the oldest entries in order
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            free_cnt <= free_cnt_t'(NUM_RRF);
        end else begin
            case ({alloc_i, commit_i})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                // both or neither, count unchanged
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    assign alloc_tag_o = alloc_ptr;
    assign free_cnt_o  = free_cnt;

endmodule

// ==== verilog.f ====
design/rename_pkg.sv
design/operand_lookup_if.sv
design/commit_if.sv
design/arch_reg_file.sv
design/rename_buffer.sv
design/rrf_allocator.sv
design/operand_resolver.sv
design/dispatch_ctrl.sv
design/rename_unit.sv
bench/tb_rename_unit.sv
